//--- hdl/sdram_pkg.sv
package sdram_pkg;

  // Word address window, two devices
  localparam int ADDR_W = 25;
  localparam int ROW_W  = 13;
  localparam int BANK_W = 2;
  localparam int COL_W  = 9;

  localparam int AP_BIT = 10; // A10 selects auto-precharge / precharge all

  typedef logic [ROW_W-1:0] sdram_a_t;

  typedef struct packed {
    logic              dev;
    logic [ROW_W-1:0]  row;
    logic [BANK_W-1:0] bank;
    logic [COL_W-1:0]  col;
  } sdram_fields_t;

  // Flat word address from APB, fields for the controller
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    sdram_fields_t     f;
  } sdram_addr_u;

  // {RAS, CAS, WE}, all active low
  typedef enum logic [2:0] {
    CMD_LOAD_MODE = 3'b000,
    CMD_REFRESH   = 3'b001,
    CMD_PRECHARGE = 3'b010,
    CMD_ACTIVE    = 3'b011,
    CMD_WRITE     = 3'b100,
    CMD_READ      = 3'b101,
    CMD_NOP       = 3'b111
  } sdram_cmd_t;

  // Clocks at system rate
  localparam int T_RCD = 2;
  localparam int T_RP  = 2;
  localparam int T_RFC = 7;
  localparam int T_WR  = 2;

  // BL1, sequential, CAS latency field [6:4] left zero
  localparam logic [9:0] MODE_BURST1 = 10'b0_00_000_0_000;

endpackage

//--- hdl/bus_pkg.sv
package bus_pkg;

  // One word transfer, bridge to controller
  typedef struct packed {
    logic                   write;
    logic [3:0]             strb;
    sdram_pkg::sdram_addr_u addr;
    logic [31:0]            wdata;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } mem_rsp_t;

endpackage

//--- hdl/apb_bridge.sv
`timescale 1ns/10ps

module apb_bridge (
  input  logic               clock,
  input  logic               reset,
  input  logic [31:0]        paddr_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [31:0]        pwdata_i,
  input  logic [3:0]         pstrb_i,
  output bus_pkg::mem_req_t  req_o,
  output logic               req_valid_o,
  input  logic               req_accept_i,
  input  bus_pkg::mem_rsp_t  rsp_i,
  input  logic               rsp_ack_i,
  output logic               pready_o,
  output logic [31:0]        prdata_o,
  output logic               pslverr_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_ACCEPT,
    ST_WAIT_ACK,
    ST_RESPOND
  } state_t;

  state_t            state_q;
  bus_pkg::mem_req_t req_q;
  logic              range_err_q;
  logic              err_q;
  logic [31:0]       rdata_q;
  logic              setup;

  assign setup = psel_i && !penable_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (setup) state_q <= ST_WAIT_ACCEPT;
        ST_WAIT_ACCEPT: begin
          if (range_err_q) state_q <= ST_RESPOND; // No SDRAM access
          else if (req_accept_i) state_q <= ST_WAIT_ACK;
        end
        ST_WAIT_ACK: if (rsp_ack_i) state_q <= ST_RESPOND;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == ST_IDLE && setup) begin
      req_q.write     <= pwrite_i;
      req_q.strb      <= pstrb_i;
      req_q.addr.flat <= paddr_i[sdram_pkg::ADDR_W+1:2];
      req_q.wdata     <= pwdata_i;
      range_err_q     <= |paddr_i[31:sdram_pkg::ADDR_W+2];
    end
    if (state_q == ST_WAIT_ACCEPT && range_err_q) begin
      rdata_q <= '0;
      err_q   <= 1'b1;
    end
    if (state_q == ST_WAIT_ACK && rsp_ack_i) begin
      rdata_q <= rsp_i.rdata;
      err_q   <= rsp_i.err;
    end
  end

  assign req_o       = req_q;
  assign req_valid_o = (state_q == ST_WAIT_ACCEPT) && !range_err_q;

  assign pready_o  = (state_q == ST_RESPOND);
  assign prdata_o  = rdata_q;
  assign pslverr_o = (state_q == ST_RESPOND) && err_q;

endmodule

//--- hdl/sdram_ctrl.sv
`timescale 1ns/10ps

module sdram_ctrl #(
  parameter int INIT_CYCLES    = 10000,
  parameter int REFRESH_CYCLES = 750,
  parameter int CAS_LATENCY    = 2
) (
  input  logic                          clock,
  input  logic                          reset,
  input  bus_pkg::mem_req_t             req_i,
  input  logic                          req_valid_i,
  output logic                          req_accept_o,
  output bus_pkg::mem_rsp_t             rsp_o,
  output logic                          rsp_ack_o,
  output logic                          sdram_cke_o,
  output logic [1:0]                    sdram_cs_n_o,
  output logic                          sdram_ras_n_o,
  output logic                          sdram_cas_n_o,
  output logic                          sdram_we_n_o,
  output sdram_pkg::sdram_a_t           sdram_a_o,
  output logic [sdram_pkg::BANK_W-1:0]  sdram_ba_o,
  output logic [3:0]                    sdram_dqm_o,
  output logic [31:0]                   sdram_dq_o,
  output logic [1:0]                    sdram_dq_oe_o,
  input  logic [1:0][31:0]              sdram_dq_i
);

  localparam int CNT_MAX = (INIT_CYCLES > 16) ? INIT_CYCLES : 16;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);
  localparam int REF_W   = $clog2(REFRESH_CYCLES + 1);

  localparam sdram_pkg::sdram_a_t A10_MASK = sdram_pkg::sdram_a_t'(1) << sdram_pkg::AP_BIT;
  localparam logic [9:0] MODE_WORD = sdram_pkg::MODE_BURST1 | (10'(CAS_LATENCY) << 4);

  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [REF_W-1:0] ref_t;

  typedef enum logic [3:0] {
    S_INIT_WAIT,
    S_INIT_PRE,
    S_INIT_REF,
    S_INIT_MODE,
    S_IDLE,
    S_RCD,
    S_RD_WAIT,
    S_WR_WAIT,
    S_REFRESH
  } state_t;

  state_t                       state_q;
  cnt_t                         cnt_q;
  logic                         init_ref_q;
  ref_t                         ref_cnt_q;
  logic                         refresh_due_q;
  logic                         refresh_start;
  sdram_pkg::sdram_cmd_t        cmd_q;
  logic [1:0]                   cs_n_q;
  logic                         cke_q;
  sdram_pkg::sdram_a_t          a_q;
  logic [sdram_pkg::BANK_W-1:0] ba_q;
  logic [3:0]                   dqm_q;
  logic [1:0]                   dq_oe_q;
  logic                         ack_q;
  bus_pkg::mem_req_t            req_q;
  logic [31:0]                  rdata_q;
  logic [1:0]                   req_sel;
  logic [1:0]                   cur_sel;

  // One-hot device select, new request and latched one
  assign req_sel = req_i.addr.f.dev ? 2'b10 : 2'b01;
  assign cur_sel = req_q.addr.f.dev ? 2'b10 : 2'b01;

  assign refresh_start = (state_q == S_IDLE) && refresh_due_q;
  assign req_accept_o  = (state_q == S_IDLE) && req_valid_i && !refresh_due_q;

  // Refresh interval timer
  always_ff @(posedge clock) begin
    if (reset) begin
      ref_cnt_q     <= '0;
      refresh_due_q <= 1'b0;
    end else begin
      if (refresh_start) refresh_due_q <= 1'b0;
      if (ref_cnt_q == ref_t'(REFRESH_CYCLES - 1)) begin
        ref_cnt_q     <= '0;
        refresh_due_q <= 1'b1;
      end else begin
        ref_cnt_q <= ref_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= S_INIT_WAIT;
      cnt_q      <= cnt_t'(INIT_CYCLES - 1);
      init_ref_q <= 1'b0;
      cmd_q      <= sdram_pkg::CMD_NOP;
      cs_n_q     <= 2'b11;
      cke_q      <= 1'b0;
      a_q        <= '0;
      ba_q       <= '0;
      dqm_q      <= '0;
      dq_oe_q    <= '0;
      ack_q      <= 1'b0;
    end else begin
      // Deselect unless a command is issued below
      cmd_q   <= sdram_pkg::CMD_NOP;
      cs_n_q  <= 2'b11;
      dqm_q   <= '0;
      dq_oe_q <= '0;
      ack_q   <= 1'b0;
      if (cnt_q != '0) cnt_q <= cnt_q - 1'b1;

      case (state_q)
        S_INIT_WAIT: begin
          if (cnt_q == '0) begin
            cke_q   <= 1'b1;
            cmd_q   <= sdram_pkg::CMD_PRECHARGE; // All banks
            cs_n_q  <= 2'b00;
            a_q     <= A10_MASK;
            cnt_q   <= cnt_t'(sdram_pkg::T_RP - 1);
            state_q <= S_INIT_PRE;
          end
        end
        S_INIT_PRE: begin
          if (cnt_q == '0) begin
            cmd_q      <= sdram_pkg::CMD_REFRESH;
            cs_n_q     <= 2'b00;
            init_ref_q <= 1'b0;
            cnt_q      <= cnt_t'(sdram_pkg::T_RFC - 1);
            state_q    <= S_INIT_REF;
          end
        end
        S_INIT_REF: begin
          if (cnt_q == '0) begin
            cs_n_q <= 2'b00;
            if (!init_ref_q) begin
              cmd_q      <= sdram_pkg::CMD_REFRESH; // Second one
              init_ref_q <= 1'b1;
              cnt_q      <= cnt_t'(sdram_pkg::T_RFC - 1);
            end else begin
              cmd_q   <= sdram_pkg::CMD_LOAD_MODE;
              a_q     <= sdram_pkg::sdram_a_t'(MODE_WORD);
              ba_q    <= '0;
              cnt_q   <= cnt_t'(1); // tMRD
              state_q <= S_INIT_MODE;
            end
          end
        end
        S_INIT_MODE: if (cnt_q == '0) state_q <= S_IDLE;
        S_IDLE: begin
          if (refresh_due_q) begin
            cmd_q   <= sdram_pkg::CMD_REFRESH;
            cs_n_q  <= 2'b00;
            cnt_q   <= cnt_t'(sdram_pkg::T_RFC - 1);
            state_q <= S_REFRESH;
          end else if (req_accept_o) begin
            cmd_q   <= sdram_pkg::CMD_ACTIVE;
            cs_n_q  <= ~req_sel;
            a_q     <= req_i.addr.f.row;
            ba_q    <= req_i.addr.f.bank;
            cnt_q   <= cnt_t'(sdram_pkg::T_RCD - 1);
            state_q <= S_RCD;
          end
        end
        S_RCD: begin
          if (cnt_q == '0) begin
            cs_n_q <= ~cur_sel;
            a_q    <= sdram_pkg::sdram_a_t'(req_q.addr.f.col) | A10_MASK;
            if (req_q.write) begin
              cmd_q   <= sdram_pkg::CMD_WRITE;
              dqm_q   <= ~req_q.strb;
              dq_oe_q <= cur_sel;
              cnt_q   <= cnt_t'(sdram_pkg::T_WR + sdram_pkg::T_RP - 1);
              state_q <= S_WR_WAIT;
            end else begin
              cmd_q   <= sdram_pkg::CMD_READ;
              cnt_q   <= cnt_t'(CAS_LATENCY);
              state_q <= S_RD_WAIT;
            end
          end
        end
        S_RD_WAIT, S_WR_WAIT: begin
          if (cnt_q == '0) begin
            ack_q   <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        S_REFRESH: if (cnt_q == '0) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (req_accept_o) req_q <= req_i;
    // Read data valid CAS latency after READ
    if (state_q == S_RD_WAIT && cnt_q == '0) rdata_q <= sdram_dq_i[req_q.addr.f.dev];
  end

  assign rsp_o     = '{rdata: rdata_q, err: 1'b0};
  assign rsp_ack_o = ack_q;

  assign sdram_cke_o   = cke_q;
  assign sdram_cs_n_o  = cs_n_q;
  assign {sdram_ras_n_o, sdram_cas_n_o, sdram_we_n_o} = cmd_q;
  assign sdram_a_o     = a_q;
  assign sdram_ba_o    = ba_q;
  assign sdram_dqm_o   = dqm_q;
  assign sdram_dq_o    = req_q.wdata;
  assign sdram_dq_oe_o = dq_oe_q;

endmodule

//--- hdl/sdram_top_apb.sv
`timescale 1ns/10ps

module sdram_top_apb #(
  parameter int INIT_CYCLES    = 10000,
  parameter int REFRESH_CYCLES = 750,
  parameter int CAS_LATENCY    = 2
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [31:0]                   paddr_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic [2:0]                    pprot_i, // Accepted, not checked
  input  logic                          pwrite_i,
  input  logic [31:0]                   pwdata_i,
  input  logic [3:0]                    pstrb_i,
  output logic                          pready_o,
  output logic [31:0]                   prdata_o,
  output logic                          pslverr_o,

  output logic                          sdram_clk_0_o,
  output logic                          sdram_cke_0_o,
  output logic                          sdram_cs_n_0_o,
  output logic                          sdram_ras_n_0_o,
  output logic                          sdram_cas_n_0_o,
  output logic                          sdram_we_n_0_o,
  output sdram_pkg::sdram_a_t           sdram_a_0_o,
  output logic [sdram_pkg::BANK_W-1:0]  sdram_ba_0_o,
  output logic [3:0]                    sdram_dqm_0_o,
  inout  wire  [31:0]                   sdram_dq_0_io,

  output logic                          sdram_clk_1_o,
  output logic                          sdram_cke_1_o,
  output logic                          sdram_cs_n_1_o,
  output logic                          sdram_ras_n_1_o,
  output logic                          sdram_cas_n_1_o,
  output logic                          sdram_we_n_1_o,
  output sdram_pkg::sdram_a_t           sdram_a_1_o,
  output logic [sdram_pkg::BANK_W-1:0]  sdram_ba_1_o,
  output logic [3:0]                    sdram_dqm_1_o,
  inout  wire  [31:0]                   sdram_dq_1_io
);

  bus_pkg::mem_req_t            req;
  logic                         req_valid;
  logic                         req_accept;
  bus_pkg::mem_rsp_t            rsp;
  logic                         rsp_ack;
  logic                         cke;
  logic [1:0]                   cs_n;
  logic                         ras_n;
  logic                         cas_n;
  logic                         we_n;
  sdram_pkg::sdram_a_t          a;
  logic [sdram_pkg::BANK_W-1:0] ba;
  logic [3:0]                   dqm;
  logic [31:0]                  dq_out;
  logic [1:0]                   dq_oe;
  logic [1:0][31:0]             dq_in;

  apb_bridge bridge_i (
    .clock        (clock),
    .reset        (reset),
    .paddr_i      (paddr_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .pwdata_i     (pwdata_i),
    .pstrb_i      (pstrb_i),
    .req_o        (req),
    .req_valid_o  (req_valid),
    .req_accept_i (req_accept),
    .rsp_i        (rsp),
    .rsp_ack_i    (rsp_ack),
    .pready_o     (pready_o),
    .prdata_o     (prdata_o),
    .pslverr_o    (pslverr_o)
  );

  sdram_ctrl #(
    .INIT_CYCLES    (INIT_CYCLES),
    .REFRESH_CYCLES (REFRESH_CYCLES),
    .CAS_LATENCY    (CAS_LATENCY)
  ) ctrl_i (
    .clock         (clock),
    .reset         (reset),
    .req_i         (req),
    .req_valid_i   (req_valid),
    .req_accept_o  (req_accept),
    .rsp_o         (rsp),
    .rsp_ack_o     (rsp_ack),
    .sdram_cke_o   (cke),
    .sdram_cs_n_o  (cs_n),
    .sdram_ras_n_o (ras_n),
    .sdram_cas_n_o (cas_n),
    .sdram_we_n_o  (we_n),
    .sdram_a_o     (a),
    .sdram_ba_o    (ba),
    .sdram_dqm_o   (dqm),
    .sdram_dq_o    (dq_out),
    .sdram_dq_oe_o (dq_oe),
    .sdram_dq_i    (dq_in)
  );

  // Clock passed straight out
  assign sdram_clk_0_o = clock;
  assign sdram_clk_1_o = clock;

  // Shared command lines
  assign sdram_cke_0_o   = cke;
  assign sdram_cke_1_o   = cke;
  assign sdram_ras_n_0_o = ras_n;
  assign sdram_ras_n_1_o = ras_n;
  assign sdram_cas_n_0_o = cas_n;
  assign sdram_cas_n_1_o = cas_n;
  assign sdram_we_n_0_o  = we_n;
  assign sdram_we_n_1_o  = we_n;
  assign sdram_a_0_o     = a;
  assign sdram_a_1_o     = a;
  assign sdram_ba_0_o    = ba;
  assign sdram_ba_1_o    = ba;
  assign sdram_dqm_0_o   = dqm;
  assign sdram_dqm_1_o   = dqm;

  assign sdram_cs_n_0_o = cs_n[0];
  assign sdram_cs_n_1_o = cs_n[1];

  assign sdram_dq_0_io = dq_oe[0] ? dq_out : 'z;
  assign sdram_dq_1_io = dq_oe[1] ? dq_out : 'z;
  assign dq_in[0] = sdram_dq_0_io;
  assign dq_in[1] = sdram_dq_1_io;

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
  parameter int PERIOD_NS = 20
) (
  output logic clock_o
);

  logic clk_q = 1'b0;

  always #(PERIOD_NS / 2) clk_q = ~clk_q;

  assign clock_o = clk_q;

endmodule

//--- tests/sdram_model.sv
`timescale 1ns/10ps

module sdram_model #(
  parameter int CAS_LATENCY = 2
) (
  input  logic                         clk_i,
  input  logic                         cke_i,
  input  logic                         cs_n_i,
  input  logic                         ras_n_i,
  input  logic                         cas_n_i,
  input  logic                         we_n_i,
  input  sdram_pkg::sdram_a_t          a_i,
  input  logic [sdram_pkg::BANK_W-1:0] ba_i,
  input  logic [3:0]                   dqm_i,
  inout  wire  [31:0]                  dq_io,
  output int                           errors_o
);

  localparam int KEY_W = sdram_pkg::BANK_W + sdram_pkg::ROW_W + sdram_pkg::COL_W;

  logic [31:0]              mem [logic [KEY_W-1:0]];
  sdram_pkg::sdram_a_t      row_q [4];
  logic [3:0]               open_q = '0;
  logic [31:0]              pipe_data [CAS_LATENCY];
  logic [CAS_LATENCY-1:0]   pipe_vld = '0;
  int                       err_cnt = 0;
  int                       clk_cnt = 0;
  int                       last_ref = -sdram_pkg::T_RFC;
  int                       last_act [4];
  sdram_pkg::sdram_cmd_t    cmd;
  logic [KEY_W-1:0]         key;
  logic [31:0]              old_word;
  logic [31:0]              keep_mask;

  assign cmd       = sdram_pkg::sdram_cmd_t'({ras_n_i, cas_n_i, we_n_i});
  assign key       = {ba_i, row_q[ba_i], a_i[sdram_pkg::COL_W-1:0]};
  assign old_word  = mem.exists(key) ? mem[key] : 32'h0;
  assign keep_mask = {{8{dqm_i[3]}}, {8{dqm_i[2]}}, {8{dqm_i[1]}}, {8{dqm_i[0]}}};
  assign dq_io     = pipe_vld[CAS_LATENCY-1] ? pipe_data[CAS_LATENCY-1] : 'z;
  assign errors_o  = err_cnt;

  always @(posedge clk_i) begin
    clk_cnt++;
    for (int i = CAS_LATENCY - 1; i > 0; i--) begin
      pipe_data[i] <= pipe_data[i-1];
      pipe_vld[i]  <= pipe_vld[i-1];
    end
    pipe_vld[0] <= 1'b0;
    if (cke_i && !cs_n_i) begin
      case (cmd)
        sdram_pkg::CMD_ACTIVE: begin
          if (open_q[ba_i]) begin
            $display("sdram_model: ACTIVE to bank %0d while a row is open", ba_i);
            err_cnt++;
          end
          if (clk_cnt - last_ref < sdram_pkg::T_RFC) begin
            $display("sdram_model: ACTIVE %0d clocks after REFRESH, tRFC is %0d",
                     clk_cnt - last_ref, sdram_pkg::T_RFC);
            err_cnt++;
          end
          last_act[ba_i] = clk_cnt;
          open_q[ba_i] <= 1'b1;
          row_q[ba_i]  <= a_i;
        end
        sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE: begin
          if (!open_q[ba_i]) begin
            $display("sdram_model: %s to bank %0d with no active row", cmd.name(), ba_i);
            err_cnt++;
          end else begin
            if (clk_cnt - last_act[ba_i] < sdram_pkg::T_RCD) begin
              $display("sdram_model: %s %0d clocks after ACTIVE, tRCD is %0d", cmd.name(),
                       clk_cnt - last_act[ba_i], sdram_pkg::T_RCD);
              err_cnt++;
            end
            if (cmd == sdram_pkg::CMD_WRITE) begin
              mem[key] = (old_word & keep_mask) | (dq_io & ~keep_mask); // Masked bytes stay
            end else begin
              pipe_data[0] <= old_word;
              pipe_vld[0]  <= 1'b1;
            end
          end
          if (a_i[sdram_pkg::AP_BIT]) open_q[ba_i] <= 1'b0;
        end
        sdram_pkg::CMD_PRECHARGE: begin
          if (a_i[sdram_pkg::AP_BIT]) open_q <= '0;
          else open_q[ba_i] <= 1'b0;
        end
        sdram_pkg::CMD_REFRESH: begin
          if (open_q != '0) begin
            $display("sdram_model: REFRESH while banks %b are open", open_q);
            err_cnt++;
          end
          if (clk_cnt - last_ref < sdram_pkg::T_RFC) begin
            $display("sdram_model: REFRESH %0d clocks after the previous one, tRFC is %0d",
                     clk_cnt - last_ref, sdram_pkg::T_RFC);
            err_cnt++;
          end
          last_ref = clk_cnt;
        end
        sdram_pkg::CMD_LOAD_MODE: begin
          if (a_i[6:4] != 3'(CAS_LATENCY)) begin
            $display("sdram_model: mode register CAS latency %0d, expected %0d",
                     a_i[6:4], CAS_LATENCY);
            err_cnt++;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/10ps

module tb_top;

  localparam int INIT_CYCLES    = 20;
  localparam int REFRESH_CYCLES = 150;
  localparam int CAS_LATENCY    = 2;
  localparam logic [31:0] SEED  = 32'ha796df69;
  localparam int N_RANDOM       = 200;
  localparam int N_ROUNDS       = 4;
  localparam int GAP_CYCLES     = REFRESH_CYCLES + 30; // Idle gap in refresh test
  localparam int N_XFERS        = N_RANDOM + 4 + 3 + 2 * N_ROUNDS;
  localparam int XFER_CYCLES    = sdram_pkg::T_RFC + sdram_pkg::T_RCD + CAS_LATENCY
                                  + sdram_pkg::T_WR + sdram_pkg::T_RP + 8;
  localparam int TIMEOUT_CYCLES = N_XFERS * XFER_CYCLES + N_ROUNDS * GAP_CYCLES
                                  + INIT_CYCLES + 100;

  logic                              clock;
  logic                              reset;
  logic [31:0]                       paddr;
  logic                              psel;
  logic                              penable;
  logic [2:0]                        pprot;
  logic                              pwrite;
  logic [31:0]                       pwdata;
  logic [3:0]                        pstrb;
  logic                              pready;
  logic [31:0]                       prdata;
  logic                              pslverr;
  logic [1:0]                        sd_clk;
  logic [1:0]                        sd_cke;
  logic [1:0]                        sd_cs_n;
  logic [1:0]                        sd_ras_n;
  logic [1:0]                        sd_cas_n;
  logic [1:0]                        sd_we_n;
  logic [1:0][sdram_pkg::ROW_W-1:0]  sd_a;
  logic [1:0][sdram_pkg::BANK_W-1:0] sd_ba;
  logic [1:0][3:0]                   sd_dqm;
  wire  [31:0]                       dq_0;
  wire  [31:0]                       dq_1;
  int                                model_err_0;
  int                                model_err_1;

  string       test_name = "init";
  int          test_errs = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          model_errs_start = 0;
  int          refresh_cnt = 0;
  int          cycle_cnt = 0;
  logic [31:0] ref_mem [logic [24:0]]; // Word address to expected data
  logic [24:0] addr_set [8];

  tb_clock #(.PERIOD_NS(20)) clock_gen_i (.clock_o(clock));

  sdram_top_apb #(
    .INIT_CYCLES    (INIT_CYCLES),
    .REFRESH_CYCLES (REFRESH_CYCLES),
    .CAS_LATENCY    (CAS_LATENCY)
  ) dut_i (
    .clock (clock), .reset (reset),
    .paddr_i (paddr), .psel_i (psel), .penable_i (penable), .pprot_i (pprot),
    .pwrite_i (pwrite), .pwdata_i (pwdata), .pstrb_i (pstrb),
    .pready_o (pready), .prdata_o (prdata), .pslverr_o (pslverr),
    .sdram_clk_0_o (sd_clk[0]), .sdram_cke_0_o (sd_cke[0]), .sdram_cs_n_0_o (sd_cs_n[0]),
    .sdram_ras_n_0_o (sd_ras_n[0]), .sdram_cas_n_0_o (sd_cas_n[0]),
    .sdram_we_n_0_o (sd_we_n[0]), .sdram_a_0_o (sd_a[0]), .sdram_ba_0_o (sd_ba[0]),
    .sdram_dqm_0_o (sd_dqm[0]), .sdram_dq_0_io (dq_0),
    .sdram_clk_1_o (sd_clk[1]), .sdram_cke_1_o (sd_cke[1]), .sdram_cs_n_1_o (sd_cs_n[1]),
    .sdram_ras_n_1_o (sd_ras_n[1]), .sdram_cas_n_1_o (sd_cas_n[1]),
    .sdram_we_n_1_o (sd_we_n[1]), .sdram_a_1_o (sd_a[1]), .sdram_ba_1_o (sd_ba[1]),
    .sdram_dqm_1_o (sd_dqm[1]), .sdram_dq_1_io (dq_1)
  );

  sdram_model #(.CAS_LATENCY(CAS_LATENCY)) dev0_i (
    .clk_i (sd_clk[0]), .cke_i (sd_cke[0]), .cs_n_i (sd_cs_n[0]),
    .ras_n_i (sd_ras_n[0]), .cas_n_i (sd_cas_n[0]), .we_n_i (sd_we_n[0]),
    .a_i (sd_a[0]), .ba_i (sd_ba[0]), .dqm_i (sd_dqm[0]), .dq_io (dq_0),
    .errors_o (model_err_0)
  );

  sdram_model #(.CAS_LATENCY(CAS_LATENCY)) dev1_i (
    .clk_i (sd_clk[1]), .cke_i (sd_cke[1]), .cs_n_i (sd_cs_n[1]),
    .ras_n_i (sd_ras_n[1]), .cas_n_i (sd_cas_n[1]), .we_n_i (sd_we_n[1]),
    .a_i (sd_a[1]), .ba_i (sd_ba[1]), .dqm_i (sd_dqm[1]), .dq_io (dq_1),
    .errors_o (model_err_1)
  );

  // Refresh commands go to both devices at once
  always @(posedge clock) begin
    if (!reset && sd_cs_n == 2'b00 && sd_cke[0]
        && {sd_ras_n[0], sd_cas_n[0], sd_we_n[0]} == sdram_pkg::CMD_REFRESH) begin
      refresh_cnt++;
    end
  end

  always @(posedge clock) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, test %s did not finish", cycle_cnt, test_name);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] expected_word(input logic [24:0] wa);
    return ref_mem.exists(wa) ? ref_mem[wa] : 32'h0; // Unwritten reads zero
  endfunction

  function automatic logic [31:0] merge_strobed(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  task automatic report_failure(input string msg);
    $display("Error in %s: %s", test_name, msg);
    test_errs++;
  endtask

  task automatic compare_word(input string what, input logic [31:0] exp,
                              input logic [31:0] got);
    assert (got === exp) else begin
      $display("Mismatch %s %s: expected %08h, actual %08h", test_name, what, exp, got);
      test_errs++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name        = name;
    test_errs        = 0;
    model_errs_start = model_err_0 + model_err_1;
  endtask

  task automatic end_test();
    assert (model_err_0 + model_err_1 == model_errs_start)
      else report_failure("SDRAM model reported bad commands");
    if (test_errs == 0) begin
      pass_cnt++;
      $display("PASS %s", test_name);
    end else begin
      fail_cnt++;
      $display("FAIL %s with %0d errors", test_name, test_errs);
    end
  endtask

  // Setup phase, access phase, then wait for PREADY
  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb,
                              output logic [31:0] rdata, output logic err,
                              output int wait_cycles);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    pstrb   <= write ? strb : 4'h0;
    pprot   <= 3'($urandom);
    @(posedge clock);
    penable <= 1'b1;
    wait_cycles = 0;
    do begin
      @(negedge clock);
      wait_cycles++;
    end while (!pready);
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_word(input logic [24:0] wa, input logic [31:0] data,
                            input logic [3:0] strb);
    logic [31:0] rdata;
    logic        err;
    int          lat;
    apb_transfer(1'b1, {5'b0, wa, 2'b00}, data, strb, rdata, err, lat);
    assert (!err) else report_failure($sformatf("write to word %07h gave PSLVERR", wa));
    ref_mem[wa] = merge_strobed(expected_word(wa), data, strb);
  endtask

  task automatic read_and_check(input logic [24:0] wa, output logic [31:0] got);
    logic err;
    int   lat;
    apb_transfer(1'b0, {5'b0, wa, 2'b00}, 32'h0, 4'h0, got, err, lat);
    assert (!err) else report_failure($sformatf("read of word %07h gave PSLVERR", wa));
    compare_word($sformatf("word %07h", wa), expected_word(wa), got);
  endtask

  task automatic check_quiet_bus();
    assert (!pready && !pslverr) else report_failure("PREADY or PSLVERR raised while idle");
    assert (dut_i.ctrl_i.sdram_dq_oe_o == 2'b00) else report_failure("dq driven while idle");
  endtask

  initial begin
    logic [31:0] got0;
    logic [31:0] got1;
    logic [31:0] data;
    logic        err;
    int          lat;
    logic [23:0] offset;
    logic [2:0]  idx;

    void'($urandom(SEED));
    reset   = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pprot   = '0;
    pwrite  = 1'b0;
    pwdata  = '0;
    pstrb   = '0;

    begin_test("after_reset");
    for (int i = 0; i < 10; i++) begin
      @(posedge clock);
      if (i == 9) reset <= 1'b0;
      @(negedge clock);
      check_quiet_bus();
    end
    repeat (30) begin
      @(negedge clock);
      check_quiet_bus();
    end
    end_test();

    begin_test("random_traffic");
    for (int i = 0; i < 8; i++) addr_set[i] = 25'($urandom);
    for (int i = 0; i < N_RANDOM; i++) begin
      idx = 3'($urandom);
      if ($urandom % 2 == 0) write_word(addr_set[idx], $urandom, 4'($urandom));
      else read_and_check(addr_set[idx], got0);
    end
    end_test();

    begin_test("device_separation");
    offset = 24'($urandom);
    data   = $urandom;
    write_word({1'b0, offset}, data, 4'hf);
    write_word({1'b1, offset}, ~data, 4'hf);
    read_and_check({1'b0, offset}, got0);
    read_and_check({1'b1, offset}, got1);
    assert (got0 != got1) else report_failure("both devices returned the same word");
    end_test();

    begin_test("out_of_range");
    apb_transfer(1'b1, {5'($urandom_range(31, 1)), addr_set[0], 2'b00},
                 ~expected_word(addr_set[0]), 4'hf, got0, err, lat);
    assert (err) else report_failure("out-of-range write completed without PSLVERR");
    assert (lat == 2) else report_failure($sformatf("range error took %0d cycles", lat));
    apb_transfer(1'b0, {5'b10000, addr_set[0], 2'b00}, 32'h0, 4'h0, got0, err, lat);
    assert (err) else report_failure("out-of-range read completed without PSLVERR");
    read_and_check(addr_set[0], got0); // Alias must be unchanged
    end_test();

    begin_test("refresh_gaps");
    lat = refresh_cnt;
    for (int r = 0; r < N_ROUNDS; r++) begin
      write_word(addr_set[r], $urandom, 4'hf);
      repeat (GAP_CYCLES) @(posedge clock);
      read_and_check(addr_set[r], got0);
    end
    assert (refresh_cnt > lat) else report_failure("no auto-refresh seen during idle gaps");
    end_test();

    $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
hdl/sdram_pkg.sv
hdl/bus_pkg.sv
hdl/apb_bridge.sv
hdl/sdram_ctrl.sv
hdl/sdram_top_apb.sv
tests/tb_clock.sv
tests/sdram_model.sv
tests/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the APB SDRAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_top \
  -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TB PASSED$"; then
  exit 0
fi
exit 1
